/* gat_cfg.svh */
// ----------------------------------------------------------
// Build-time sizes for the GAT edge attention-score stage.
// Included by the packages and by modules that need defaults.
// ----------------------------------------------------------
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// ----------------------------------------------------------
// Data widths
// ----------------------------------------------------------
`define GAT_SCORE_W      16  // Signed fixed-point score and coefficient.
`define GAT_EDGE_W       12  // Edge id carried alongside each score.

// ----------------------------------------------------------
// Buffering
// ----------------------------------------------------------
`define GAT_FIFO_DEPTH   8   // Entries per score FIFO, a power of two.

// ----------------------------------------------------------
// Activation
// ----------------------------------------------------------
`define GAT_LRELU_SHIFT  3   // Negative slope is 1/2^shift.

`endif

/* src/fifo_pkg.sv */
// ----------------------------------------------------------
// Buffer status type shared by the score FIFOs, the
// combiner and the top level.
// ----------------------------------------------------------
package fifo_pkg;

  // ----------------------------------------------------------
  // Occupancy flags
  // ----------------------------------------------------------
  // All four flags are decoded from the pointer pair in the
  // FIFO and move as one bundle to whoever watches the buffer.
  typedef struct packed {
    logic empty;         // No entry held.
    logic almost_empty;  // Exactly one entry held.
    logic full;          // Every slot holds an entry.
    logic almost_full;   // One slot left free.
  } fifo_status_t;

endpackage

/* src/attn_pkg.sv */
// ----------------------------------------------------------
// Score and coefficient types for the edge attention stage.
// Import wherever scores or edge ids are handled.
// ----------------------------------------------------------
`include "gat_cfg.svh"

package attn_pkg;

  // ----------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------
  typedef logic signed [`GAT_SCORE_W-1:0] score_t;    // Fixed-point score.
  typedef logic        [`GAT_EDGE_W-1:0]  edge_id_t;  // Edge identifier.

  // ----------------------------------------------------------
  // Stream entries
  // ----------------------------------------------------------
  // Source-side entry, the edge id rides with its score so the
  // neighbor stream can stay a bare score.
  typedef struct packed {
    edge_id_t edge_id;  // Edge this score belongs to.
    score_t   score;    // Source-side partial score.
  } src_entry_t;

  // Result handed downstream after the activation.
  typedef struct packed {
    edge_id_t edge_id;  // Edge id copied from the source entry.
    score_t   coef;     // Saturated LeakyReLU of the summed score.
  } coef_entry_t;

  // Handy widths for sizing the FIFO instances.
  localparam int SRC_ENTRY_W = $bits(src_entry_t);
  localparam int SCORE_W     = $bits(score_t);

endpackage

/* src/score_fifo.sv */
// ----------------------------------------------------------
// Synchronous FIFO with a combinational head word and four
// occupancy flags. DEPTH must be a power of two.
// ----------------------------------------------------------
`include "gat_cfg.svh"

module score_fifo
  import fifo_pkg::*;
#(
  parameter int DATA_WIDTH = `GAT_SCORE_W,
  parameter int DEPTH      = `GAT_FIFO_DEPTH
)(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  wr,      // Write strobe, ignored when full.
  input  logic [DATA_WIDTH-1:0] din,
  input  logic                  rd,      // Read strobe, ignored when empty.
  output logic [DATA_WIDTH-1:0] dout,    // Head entry, valid while not empty.

  output fifo_status_t          status
);

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int PTR_W  = ADDR_W + 1;    // Extra bit tells wrap laps apart.

  // ----------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------
  logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [PTR_W-1:0]  count;              // Entries currently held.
  logic              wr_en;
  logic              rd_en;

  assign wr_addr = wr_ptr[ADDR_W-1:0];
  assign rd_addr = rd_ptr[ADDR_W-1:0];
  assign count   = wr_ptr - rd_ptr;      // Modulo 2*DEPTH distance.

  // ----------------------------------------------------------
  // Flags
  // ----------------------------------------------------------
  // Full when the addresses meet on different laps, empty when
  // the pointers are identical.
  assign status.empty        = (wr_ptr == rd_ptr);
  assign status.full         = (wr_addr == rd_addr) &&
                               (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);
  assign status.almost_empty = (count == PTR_W'(1));
  assign status.almost_full  = (count == PTR_W'(DEPTH - 1));

  // Requests that actually take effect.
  assign wr_en = wr && !status.full;
  assign rd_en = rd && !status.empty;

  assign dout = mem[rd_addr];            // Head is read without a register.

  // ----------------------------------------------------------
  // Sequential logic
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;           // Natural wrap, depth is 2^ADDR_W.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

/* src/edge_score_combiner.sv */
// ----------------------------------------------------------
// Pairs source and neighbor scores, applies LeakyReLU with
// saturation and registers one coefficient per pop.
// ----------------------------------------------------------
`include "gat_cfg.svh"

module edge_score_combiner
  import fifo_pkg::*;
  import attn_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  input  fifo_status_t src_status,
  input  fifo_status_t nbr_status,
  input  src_entry_t   src_head,     // Head of the source FIFO.
  input  score_t       nbr_head,     // Head of the neighbor FIFO.

  output logic         pop,          // Read strobe for both FIFOs.

  output logic         out_vld,
  output coef_entry_t  out_coef
);

  localparam int W = `GAT_SCORE_W;

  localparam score_t SCORE_MAX = {1'b0, {(W-1){1'b1}}};
  localparam score_t SCORE_MIN = {1'b1, {(W-1){1'b0}}};

  // ----------------------------------------------------------
  // Pairing
  // ----------------------------------------------------------
  // Both FIFOs fill in arrival order, so popping them together
  // keeps the k-th source entry lined up with the k-th score.
  assign pop = !src_status.empty && !nbr_status.empty;

  // ----------------------------------------------------------
  // Sum, activation and clamp
  // ----------------------------------------------------------
  logic signed [W:0] sum;            // One guard bit so the add cannot wrap.
  logic signed [W:0] lrelu;
  score_t            coef_sat;

  assign sum = {src_head.score[W-1], src_head.score} + {nbr_head[W-1], nbr_head};

  // Negative sums get the 1/2^shift slope, arithmetic shift keeps the sign.
  assign lrelu = sum[W] ? (sum >>> `GAT_LRELU_SHIFT) : sum;

  always_comb begin
    if (lrelu[W] != lrelu[W-1]) begin
      coef_sat = lrelu[W] ? SCORE_MIN : SCORE_MAX;  // Out of range, pin to a limit.
    end else begin
      coef_sat = lrelu[W-1:0];
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= pop;                // One-cycle strobe per pop.
    end
  end

  // The coefficient only changes on a pop and is read under out_vld.
  always_ff @(posedge clk) begin
    if (pop) begin
      out_coef.edge_id <= src_head.edge_id;
      out_coef.coef    <= coef_sat;
    end
  end

endmodule

/* src/attn_score_top.sv */
// ----------------------------------------------------------
// Edge attention-score stage. Buffers both score streams and
// emits one LeakyReLU coefficient per matched edge.
// ----------------------------------------------------------
`include "gat_cfg.svh"

module attn_score_top
  import fifo_pkg::*;
  import attn_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  // Source-side stream, score tagged with its edge id.
  input  logic         src_wr,
  input  src_entry_t   src_in,

  // Neighbor-side stream, bare score in edge order.
  input  logic         nbr_wr,
  input  score_t       nbr_in,

  // Producers watch these for full before writing.
  output fifo_status_t src_status,
  output fifo_status_t nbr_status,

  output logic         out_vld,
  output coef_entry_t  out_coef
);

  // ----------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------
  src_entry_t src_head;
  score_t     nbr_head;
  logic       pop;                   // Shared read strobe.

  // ----------------------------------------------------------
  // Input buffers
  // ----------------------------------------------------------
  score_fifo #(
    .DATA_WIDTH (SRC_ENTRY_W),
    .DEPTH      (`GAT_FIFO_DEPTH)
  ) src_fifo0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (src_wr),
    .din    (src_in),
    .rd     (pop),
    .dout   (src_head),
    .status (src_status)
  );

  score_fifo #(
    .DATA_WIDTH (SCORE_W),
    .DEPTH      (`GAT_FIFO_DEPTH)
  ) nbr_fifo0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (nbr_wr),
    .din    (nbr_in),
    .rd     (pop),
    .dout   (nbr_head),
    .status (nbr_status)
  );

  // ----------------------------------------------------------
  // Combiner
  // ----------------------------------------------------------
  edge_score_combiner comb0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .src_status (src_status),
    .nbr_status (nbr_status),
    .src_head   (src_head),
    .nbr_head   (nbr_head),
    .pop        (pop),
    .out_vld    (out_vld),
    .out_coef   (out_coef)
  );

endmodule

/* sim/attn_score_properties.sv */
// ------------------------------------------------------------
// Concurrent checks on FIFO flags and combiner pops, bound
// into every attn_score_top instance.
// ------------------------------------------------------------
module attn_score_properties
  import fifo_pkg::*;
(
  input logic         clk,
  input logic         rst_n,
  input fifo_status_t src_status,
  input fifo_status_t nbr_status,
  input logic         pop,
  input logic         out_vld
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // Number of assertion failures so far.

  // A buffer cannot be empty and full in the same cycle.
  no_empty_and_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(src_status.empty && src_status.full) && !(nbr_status.empty && nbr_status.full))
    else begin
      fail_count++;
      $error("A FIFO status reports empty and full together.");
    end

  // The shared read strobe must only fire when both buffers hold data.
  pop_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (!src_status.empty && !nbr_status.empty))
    else begin
      fail_count++;
      $error("pop raised while a FIFO was empty.");
    end

  // Every output strobe comes from a pop one cycle earlier.
  vld_follows_pop: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld |-> $past(pop))
    else begin
      fail_count++;
      $error("out_vld raised without a pop in the previous cycle.");
    end

endmodule

bind attn_score_top attn_score_properties props0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .src_status (src_status),
  .nbr_status (nbr_status),
  .pop        (pop),
  .out_vld    (out_vld)
);

/* sim/attn_score_tb.sv */
// ------------------------------------------------------------
// Directed testbench for the edge attention-score stage.
// Models both FIFOs with queues and checks every coefficient.
// ------------------------------------------------------------
`include "gat_cfg.svh"

module attn_score_tb
  import fifo_pkg::*;
  import attn_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH      = `GAT_FIFO_DEPTH;
  localparam int MAX_CYCLES = 2000;                    // Tests need about 600 cycles.
  localparam int SCORE_HI   = 2 ** (`GAT_SCORE_W - 1) - 1;
  localparam int SCORE_LO   = -(2 ** (`GAT_SCORE_W - 1));
  localparam int RAND_WRITES = 200;

  logic         clk;
  logic         rst_n;
  logic         src_wr;
  src_entry_t   src_in;
  logic         nbr_wr;
  score_t       nbr_in;
  fifo_status_t src_status;
  fifo_status_t nbr_status;
  logic         out_vld;
  coef_entry_t  out_coef;

  src_entry_t   src_q[$];                              // Model of the source FIFO.
  score_t       nbr_q[$];                              // Model of the neighbor FIFO.
  coef_entry_t  exp_q[$];                              // Coefficients still to come out.
  logic [31:0]  lfsr_state = 32'h73d7_2b8b;
  int           cycles = 0;
  int           coef_count = 0;
  logic         model_pop;
  src_entry_t   model_src;
  score_t       model_nbr;
  coef_entry_t  seen_want;

  attn_score_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .src_wr     (src_wr),
    .src_in     (src_in),
    .nbr_wr     (nbr_wr),
    .nbr_in     (nbr_in),
    .src_status (src_status),
    .nbr_status (nbr_status),
    .out_vld    (out_vld),
    .out_coef   (out_coef)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reporting and compare tasks
  // ------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_coef(input string name, input coef_entry_t got, input coef_entry_t want);
    if (got !== want) begin
      abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_status(input string name, input fifo_status_t got,
                              input fifo_status_t want);
    if (got !== want) begin
      abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, want));
    end
  endtask

  // ------------------------------------------------------------
  // Random source and expected values
  // ------------------------------------------------------------
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];  // Taps 32,22,2,1.
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic coef_entry_t expected_coef(input src_entry_t s, input score_t n);
    int          sum;
    coef_entry_t e;
    sum = int'(s.score) + int'(n);
    if (sum < 0) begin
      sum = sum >>> `GAT_LRELU_SHIFT;                  // Slope of 1/2^shift below zero.
    end
    if (sum > SCORE_HI) begin
      sum = SCORE_HI;
    end else if (sum < SCORE_LO) begin
      sum = SCORE_LO;
    end
    e.edge_id = s.edge_id;
    e.coef    = score_t'(sum);
    return e;
  endfunction

  function automatic fifo_status_t status_for(input int count);
    fifo_status_t st;
    st.empty        = (count == 0);
    st.almost_empty = (count == 1);
    st.full         = (count == DEPTH);
    st.almost_full  = (count == DEPTH - 1);
    return st;
  endfunction

  // ------------------------------------------------------------
  // Model, monitor and timeout
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      model_pop = (src_q.size() != 0) && (nbr_q.size() != 0);  // Decided on pre-edge state.
      if (src_wr && src_q.size() < DEPTH) begin
        src_q.push_back(src_in);
      end
      if (nbr_wr && nbr_q.size() < DEPTH) begin
        nbr_q.push_back(nbr_in);
      end
      if (model_pop) begin
        model_src = src_q.pop_front();
        model_nbr = nbr_q.pop_front();
        exp_q.push_back(expected_coef(model_src, model_nbr));
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && out_vld) begin
      if (exp_q.size() == 0) begin
        abort_run("out_vld rose while no coefficient was expected.");
      end
      seen_want = exp_q.pop_front();
      check_coef("out_coef", out_coef, seen_want);
      coef_count++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout, the run reached %0d cycles.", MAX_CYCLES));
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic drive(input logic sw, input src_entry_t se, input logic nw, input score_t ns);
    src_wr = sw;
    src_in = se;
    nbr_wr = nw;
    nbr_in = ns;
    @(negedge clk);                                    // Inputs cross one rising edge.
  endtask

  task automatic drain();
    src_wr = 1'b0;
    nbr_wr = 1'b0;
    while (exp_q.size() != 0 || (src_q.size() != 0 && nbr_q.size() != 0)) begin
      @(negedge clk);
    end
  endtask

  task automatic check_both_empty();
    check_status("src_status", src_status, status_for(0));
    check_status("nbr_status", nbr_status, status_for(0));
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_single_pair();
    src_entry_t  se;
    coef_entry_t want;
    se.edge_id = 12'h011;
    se.score   = 16'sd100;
    want = expected_coef(se, 16'sd250);
    drive(1'b1, se, 1'b1, 16'sd250);
    if (out_vld) begin
      abort_run("out_vld rose one cycle early for a simultaneous pair.");
    end
    drive(1'b0, se, 1'b0, '0);
    if (!out_vld) begin
      abort_run("out_vld missing in the cycle after the second rising edge.");
    end
    check_coef("out_coef", out_coef, want);
    drain();
    check_both_empty();
  endtask

  task automatic test_activation();
    int         src_val[7] = '{-30, 30000, -30000, -32768, 32767, 0, -100};
    int         nbr_val[7] = '{-50, 10000, -30000, -32768, 0, -1, 100};
    src_entry_t se;
    for (int i = 0; i < 7; i++) begin
      se.edge_id = edge_id_t'(12'h200 + i);
      se.score   = score_t'(src_val[i]);
      drive(1'b1, se, 1'b1, score_t'(nbr_val[i]));   // Back to back, one per cycle.
    end
    drain();
    check_both_empty();
  endtask

  task automatic test_late_neighbor();
    src_entry_t se;
    for (int i = 0; i < 4; i++) begin
      se.edge_id = edge_id_t'(12'h300 + i);
      se.score   = score_t'(1000 * i - 1500);
      drive(1'b1, se, 1'b0, '0);
    end
    for (int i = 0; i < 20; i++) begin
      drive(1'b0, se, 1'b0, '0);
      if (out_vld) begin
        abort_run("out_vld appeared before any neighbor score arrived.");
      end
    end
    check_status("src_status", src_status, status_for(4));
    for (int i = 0; i < 4; i++) begin
      drive(1'b0, se, 1'b1, score_t'(700 - 300 * i));
    end
    drain();
    check_both_empty();
  endtask

  task automatic test_fill_flags();
    src_entry_t se;
    int         base;
    for (int i = 1; i <= DEPTH + 1; i++) begin
      se.edge_id = edge_id_t'(12'h400 + i);
      se.score   = score_t'(500 * i - 2000);
      drive(1'b1, se, 1'b0, '0);                       // The last write hits a full FIFO.
      check_status("src_status", src_status, status_for(i > DEPTH ? DEPTH : i));
      check_status("nbr_status", nbr_status, status_for(0));
    end
    base = coef_count;
    for (int i = 0; i < DEPTH; i++) begin
      drive(1'b0, se, 1'b1, score_t'(250 * i - 900));
    end
    drain();
    if (coef_count - base != DEPTH) begin
      abort_run($sformatf("The fill test drained %0d coefficients instead of %0d.",
                          coef_count - base, DEPTH));
    end
    check_both_empty();
  endtask

  task automatic test_random_stream();
    src_entry_t se;
    score_t     ns;
    logic       sw;
    logic       nw;
    logic       src_coin;
    logic       nbr_coin;
    int         src_n;
    int         nbr_n;
    src_n = 0;
    nbr_n = 0;
    while (src_n < RAND_WRITES || nbr_n < RAND_WRITES) begin
      check_status("src_status", src_status, status_for(src_q.size()));
      check_status("nbr_status", nbr_status, status_for(nbr_q.size()));
      src_coin   = lfsr_bit() | lfsr_bit();            // Source runs faster so it fills up.
      nbr_coin   = lfsr_bit();
      se.edge_id = edge_id_t'(rand_bits(`GAT_EDGE_W));
      se.score   = score_t'(rand_bits(`GAT_SCORE_W));
      ns         = score_t'(rand_bits(`GAT_SCORE_W));
      sw = src_coin && !src_status.full && (src_n < RAND_WRITES);
      nw = nbr_coin && !nbr_status.full && (nbr_n < RAND_WRITES);
      drive(sw, se, nw, ns);
      if (sw) begin
        src_n++;
      end
      if (nw) begin
        nbr_n++;
      end
    end
    drain();
    check_both_empty();
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rst_n  = 1'b0;
    src_wr = 1'b0;
    src_in = '0;
    nbr_wr = 1'b0;
    nbr_in = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_both_empty();
    test_single_pair();
    test_activation();
    test_late_neighbor();
    test_fill_flags();
    test_random_stream();
    if (exp_q.size() != 0 || src_q.size() != 0 || nbr_q.size() != 0) begin
      abort_run("Entries were left outstanding at the end of the run.");
    end
    if (dut0.props0.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
src/fifo_pkg.sv
src/attn_pkg.sv
src/score_fifo.sv
src/edge_score_combiner.sv
src/attn_score_top.sv
sim/attn_score_properties.sv
sim/attn_score_tb.sv

/* Makefile */
# Verilator build and run for the edge attention-score stage.
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = attn_score_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := gat_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
